// ==== src/chipRam_cfg.svh ====
`ifndef CHIPRAM_CFG_SVH
`define CHIPRAM_CFG_SVH

////////////////////
// Refresh
////////////////////

// 8192 rows every 64 ms, one request per interval
`define REFRESH_CNT_W 8
`define REFRESH_PERIOD 8'd120

// Consecutive CAS cycles before a CPU slot opens
`define CAS_CNT_W 4
`define CAS_GAP_CNT 4'd8

////////////////////
// Sequencer steps
////////////////////

`define STEP_W 5
`define STEP_IDLE 5'd0
`define STEP_FIRST 5'd1

// Power-up sequence
`define INIT_MODE_STEP 5'd2
`define INIT_REF1_STEP 5'd5
`define INIT_REF2_STEP 5'd10
`define INIT_DONE_STEP 5'd15

// Refresh cycle end
`define REF_END_STEP 5'd4

// Single-word access
`define CYC_RW_STEP 5'd6
`define CYC_PRE_STEP 5'd7
`define CYC_TACK_CLR_STEP 5'd8
`define CYC_WEND_STEP 5'd9
`define CYC_RTACK_STEP 5'd11
`define CYC_DEND_STEP 5'd12
`define CYC_CEND_STEP 5'd14

// Mode register, CL 2 and 4-word sequential bursts
`define MODE_WORD_CL 3'd2
`define MODE_WORD_BL 3'b010

`endif

// ==== src/chipRamPkg.sv ====
package chipRamPkg;

    // Command bits are {csN, rasN, casN, weN}
    typedef enum logic [3:0] {
        NOP         = 4'b1111,
        PRECHARGE   = 4'b0010,
        ACTIVATE    = 4'b0011,
        READ        = 4'b0101,
        WRITE       = 4'b0100,
        AUTOREFRESH = 4'b0001,
        MODEREG     = 4'b0000
    } sdramCmdE;

    // CMA lines, read as an address or as the mode word
    typedef union packed {
        struct packed {
            // Auto precharge, or all banks on PRECHARGE
            logic       a10;
            logic [9:0] rowCol;
        } addrView;
        struct packed {
            logic       rsvd;
            logic       wbMode;
            logic [1:0] opMode;
            logic [2:0] casLat;
            // Zero for sequential
            logic       burstType;
            logic [2:0] burstLen;
        } modeView;
    } sdramAddrU;

    // SDRAM pins
    typedef struct packed {
        logic       csN;
        logic       rasN;
        logic       casN;
        logic       weN;
        logic [1:0] bank;
        sdramAddrU  cma;
    } sdramBusT;

    // DMA chip DRAM side
    typedef struct packed {
        logic [1:0] rasN;
        // Upper and lower byte strobes
        logic [1:0] casN;
        logic       aweN;
        logic       dbrN;
        logic [9:0] dra;
    } agnusBusT;

    // CPU request, longword address
    typedef struct packed {
        logic        tsN;
        logic        ramSpaceN;
        logic        rnW;
        logic [20:2] addr;
    } cpuReqT;

    // Latched DMA address
    typedef struct packed {
        logic [9:0] row;
        logic [8:0] col;
        logic       a1;
    } dmaAddrT;

    typedef struct packed {
        logic dmaCycle;
        logic dmaWriteCycle;
        logic latchClk;
        logic dbEnN;
        logic dbDir;
    } dmaStatusT;

    typedef struct packed {
        logic cpuCycle;
        logic cpuTack;
        logic clkEn;
    } cpuStatusT;

endpackage

// ==== src/dmaAddrLatch.sv ====
module dmaAddrLatch import chipRamPkg::*; (
    input  logic     C1,
    input  logic     REFRESH_RST,
    input  agnusBusT agnusBus,
    input  logic     agnusRev,
    output dmaAddrT  dmaAddr
);

    logic rasActive;
    logic casActive;
    logic rasActD;
    logic rasActDD;
    logic casActD;
    logic rowLoad;
    logic colLoad;

    // Exactly one RAS line low during a row strobe
    assign rasActive = agnusBus.rasN[1] ^ agnusBus.rasN[0];
    // Either byte strobe
    assign casActive = ~&agnusBus.casN;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            rasActD  <= 1'b0;
            rasActDD <= 1'b0;
            casActD  <= 1'b0;
        end else begin
            rasActD  <= rasActive;
            rasActDD <= rasActD;
            casActD  <= casActive;
        end
    end

    // Row one cycle after the RAS fall
    assign rowLoad = !agnusBus.dbrN && rasActD && !rasActDD;
    // Column on the first CAS cycle
    assign colLoad = !agnusBus.dbrN && casActive && !casActD;

    always_ff @(posedge C1) begin
        if (rowLoad) begin
            // Earlier revision has no MA9, A19 rides on RAS0
            dmaAddr.row <= agnusRev ? agnusBus.dra : {agnusBus.rasN[0], agnusBus.dra[9:1]};
        end
        if (colLoad) begin
            if (agnusRev) begin
                dmaAddr.col <= agnusBus.dra[9:1];
                dmaAddr.a1  <= agnusBus.dra[0];
            end else begin
                dmaAddr.col <= {1'b0, agnusBus.dra[9:2]};
                dmaAddr.a1  <= agnusBus.dra[1];
            end
        end
    end

endmodule

// ==== src/agnusSync.sv ====
`include "chipRam_cfg.svh"

module agnusSync import chipRamPkg::*; (
    input  logic     C1,
    input  logic     REFRESH_RST,
    input  agnusBusT agnusBus,
    input  logic     dmaAccept,
    output logic     dmaStart,
    output logic     slotBlock
);

    logic [5:0]            rasShift;
    logic [1:0]            casSync;
    logic [1:0]            dbrSync;
    logic [`CAS_CNT_W-1:0] casCnt;
    logic                  startCond;
    logic                  startCondQ;

    // RAS held two stages and CAS not yet seen
    assign startCond = rasShift[5] && rasShift[4] && !casSync[1];

    ////////////////////
    // Strobe sync
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            rasShift   <= '0;
            casSync    <= '0;
            dbrSync    <= 2'b11;
            startCondQ <= 1'b0;
            dmaStart   <= 1'b0;
        end else begin
            rasShift   <= {rasShift[4:0], agnusBus.rasN[1] != agnusBus.rasN[0]};
            casSync    <= {casSync[0], ~&agnusBus.casN};
            dbrSync    <= {dbrSync[0], agnusBus.dbrN};
            startCondQ <= startCond;
            // One start per DMA cycle, held for the sequencer
            if (startCond && !startCondQ) begin
                dmaStart <= 1'b1;
            end else if (dmaAccept) begin
                dmaStart <= 1'b0;
            end
        end
    end

    ////////////////////
    // CPU slot window
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            casCnt    <= '0;
            slotBlock <= 1'b1;
        end else if (dbrSync[1]) begin
            // Bus free of DMA requests, wait out CAS only
            casCnt    <= '0;
            slotBlock <= casSync[1];
        end else if (casSync[1]) begin
            // Long CAS run leaves room for one CPU access
            if (casCnt != `CAS_GAP_CNT) begin
                casCnt <= casCnt + 1'b1;
            end
            slotBlock <= (casCnt != `CAS_GAP_CNT);
        end else begin
            casCnt    <= '0;
            slotBlock <= 1'b1;
        end
    end

endmodule

// ==== src/refreshTimer.sv ====
`include "chipRam_cfg.svh"

module refreshTimer (
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic refreshDone,
    output logic refreshReq
);

    logic [`REFRESH_CNT_W-1:0] refCnt;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            refCnt     <= '0;
            refreshReq <= 1'b0;
        end else if (refreshDone) begin
            // Restart interval on every AUTOREFRESH
            refCnt     <= '0;
            refreshReq <= 1'b0;
        end else begin
            // Saturate, request stays up until served
            if (refCnt != '1) begin
                refCnt <= refCnt + 1'b1;
            end
            refreshReq <= (refCnt > `REFRESH_PERIOD);
        end
    end

endmodule

// ==== src/sdramSequencer.sv ====
`include "chipRam_cfg.svh"

module sdramSequencer import chipRamPkg::*; (
    input  logic      C1,
    input  logic      REFRESH_RST,
    input  cpuReqT    cpuReq,
    input  logic      agnusRev,
    // Active low, straight from the DMA chip
    input  logic      agnusWe,
    input  dmaAddrT   dmaAddr,
    input  logic      dmaStart,
    input  logic      slotBlock,
    input  logic      refreshReq,
    output logic      refreshDone,
    output logic      dmaAccept,
    output sdramBusT  sdram,
    output dmaStatusT dmaStatus,
    output cpuStatusT cpuStatus
);

    sdramCmdE           cmd;
    logic [`STEP_W-1:0] step;
    logic               configured;
    logic               cpuPend;
    logic               writeCycle;
    logic [9:0]         cpuRow;
    logic [8:0]         cpuCol;
    logic               cpuStrobe;
    logic               idle;
    logic               dmaGrant;
    logic               refGrant;
    logic               cpuGrant;

    assign cpuStrobe = !cpuReq.tsN && !cpuReq.ramSpaceN;

    // Priority DMA, refresh, CPU
    assign idle     = configured && (step == `STEP_IDLE);
    assign dmaGrant = idle && dmaStart;
    assign refGrant = idle && !dmaStart && refreshReq && !slotBlock;
    assign cpuGrant = idle && !dmaStart && !refGrant && cpuPend && !slotBlock;

    // CPU address split, MA9 only on the later revision
    always_ff @(posedge C1) begin
        if (cpuGrant) begin
            cpuRow <= {cpuReq.addr[19], cpuReq.addr[17:9]};
            cpuCol <= agnusRev ? {cpuReq.addr[20], cpuReq.addr[18], cpuReq.addr[8:2]}
                               : {1'b0, cpuReq.addr[18], cpuReq.addr[8:2]};
        end
    end

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            cmd                     <= NOP;
            step                    <= `STEP_IDLE;
            configured              <= 1'b0;
            cpuPend                 <= 1'b0;
            writeCycle              <= 1'b0;
            refreshDone             <= 1'b0;
            dmaAccept               <= 1'b0;
            sdram                   <= '{csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1,
                                         bank: 2'b00, cma: '0};
            dmaStatus               <= '{dmaCycle: 1'b0, dmaWriteCycle: 1'b0, latchClk: 1'b0,
                                         dbEnN: 1'b1, dbDir: 1'b1};
            cpuStatus               <= '{cpuCycle: 1'b0, cpuTack: 1'b0, clkEn: 1'b1};
        end else begin

            ////////////////////
            // Pin stage
            ////////////////////

            // Pins follow the command register by one cycle
            {sdram.csN, sdram.rasN, sdram.casN, sdram.weN} <= cmd;
            sdram.bank  <= 2'b00;
            refreshDone <= (cmd == AUTOREFRESH);
            dmaAccept   <= dmaGrant;
            // Request remembered until its ACTIVATE
            cpuPend     <= (cpuPend || cpuStrobe) && !cpuGrant;

            case (cmd)
                PRECHARGE: begin
                    // All banks
                    sdram.cma.addrView.a10    <= 1'b1;
                    sdram.cma.addrView.rowCol <= '0;
                end
                MODEREG: begin
                    sdram.cma.modeView.rsvd      <= 1'b0;
                    sdram.cma.modeView.wbMode    <= 1'b0;
                    sdram.cma.modeView.opMode    <= 2'b00;
                    sdram.cma.modeView.casLat    <= `MODE_WORD_CL;
                    sdram.cma.modeView.burstType <= 1'b0;
                    sdram.cma.modeView.burstLen  <= `MODE_WORD_BL;
                end
                ACTIVATE: begin
                    sdram.cma.addrView.a10    <= 1'b0;
                    sdram.cma.addrView.rowCol <= cpuStatus.cpuCycle ? cpuRow : dmaAddr.row;
                end
                READ, WRITE: begin
                    // No auto precharge, explicit PRECHARGE follows
                    sdram.cma.addrView.a10    <= 1'b0;
                    sdram.cma.addrView.rowCol <= {1'b0, cpuStatus.cpuCycle ? cpuCol : dmaAddr.col};
                end
                default: begin
                    // Address lines hold
                end
            endcase

            ////////////////////
            // Command stage
            ////////////////////

            if (step != `STEP_IDLE) begin
                step <= step + 1'b1;
            end
            cmd <= NOP;

            if (!configured) begin
                // Power-up sequence
                case (step)
                    `STEP_IDLE: begin
                        cmd  <= PRECHARGE;
                        step <= `STEP_FIRST;
                    end
                    `INIT_MODE_STEP: cmd <= MODEREG;
                    `INIT_REF1_STEP, `INIT_REF2_STEP: cmd <= AUTOREFRESH;
                    `INIT_DONE_STEP: begin
                        configured <= 1'b1;
                        step       <= `STEP_IDLE;
                    end
                    default: begin
                    end
                endcase
            end else begin
                case (step)
                    `STEP_IDLE: begin
                        if (dmaGrant) begin
                            cmd                     <= ACTIVATE;
                            step                    <= `CYC_RW_STEP;
                            writeCycle              <= !agnusWe;
                            dmaStatus.dmaCycle      <= 1'b1;
                            dmaStatus.dmaWriteCycle <= !agnusWe;
                            dmaStatus.dbDir         <= !agnusWe;
                            // Word half picked by A1
                            dmaStatus.dbEnN         <= !dmaAddr.a1;
                        end else if (refGrant) begin
                            cmd  <= AUTOREFRESH;
                            step <= `STEP_FIRST;
                        end else if (cpuGrant) begin
                            cmd                <= ACTIVATE;
                            step               <= `CYC_RW_STEP;
                            writeCycle         <= !cpuReq.rnW;
                            cpuStatus.cpuCycle <= 1'b1;
                        end
                    end
                    // Refresh needs a few idle cycles
                    `REF_END_STEP: step <= `STEP_IDLE;
                    `CYC_RW_STEP: cmd <= writeCycle ? WRITE : READ;
                    `CYC_PRE_STEP: begin
                        cmd               <= PRECHARGE;
                        // CPU write acknowledged with WRITE at the pins
                        cpuStatus.cpuTack <= writeCycle && cpuStatus.cpuCycle;
                    end
                    `CYC_TACK_CLR_STEP: cpuStatus.cpuTack <= 1'b0;
                    `CYC_WEND_STEP: begin
                        // Writes finish here
                        if (writeCycle) begin
                            cpuStatus.cpuCycle      <= 1'b0;
                            dmaStatus.dmaCycle      <= 1'b0;
                            dmaStatus.dmaWriteCycle <= 1'b0;
                            dmaStatus.dbEnN         <= 1'b1;
                            dmaStatus.dbDir         <= 1'b1;
                            step                    <= `STEP_IDLE;
                        end
                    end
                    `CYC_RTACK_STEP: begin
                        // Read data valid, CL 2 plus bus delay
                        if (cpuStatus.cpuCycle) begin
                            cpuStatus.cpuTack <= 1'b1;
                            cpuStatus.clkEn   <= 1'b0;
                        end
                        dmaStatus.latchClk <= dmaStatus.dmaCycle;
                    end
                    `CYC_DEND_STEP: begin
                        cpuStatus.cpuTack  <= 1'b0;
                        dmaStatus.latchClk <= 1'b0;
                        // DMA reads finish here
                        if (dmaStatus.dmaCycle) begin
                            dmaStatus.dmaCycle <= 1'b0;
                            dmaStatus.dbEnN    <= 1'b1;
                            step               <= `STEP_IDLE;
                        end
                    end
                    `CYC_CEND_STEP: begin
                        // CPU reads finish, clock released
                        cpuStatus.clkEn    <= 1'b1;
                        cpuStatus.cpuCycle <= 1'b0;
                        step               <= `STEP_IDLE;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/chipRamTop.sv ====
module chipRamTop import chipRamPkg::*; (
    input  logic      C1,
    input  logic      REFRESH_RST,
    input  agnusBusT  agnusBus,
    input  cpuReqT    cpuReq,
    // High for the later DMA chip revision
    input  logic      agnusRev,
    output sdramBusT  sdram,
    output dmaStatusT dmaStatus,
    output cpuStatusT cpuStatus
);

    dmaAddrT dmaAddr;
    logic    dmaStart;
    logic    slotBlock;
    logic    refreshReq;
    logic    refreshDone;
    logic    dmaAccept;

    // DMA row and column capture
    dmaAddrLatch dmaAddrLatch_inst (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .agnusBus    (agnusBus),
        .agnusRev    (agnusRev),
        .dmaAddr     (dmaAddr)
    );

    // DMA cycle start and CPU slot window
    agnusSync agnusSync_inst (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .agnusBus    (agnusBus),
        .dmaAccept   (dmaAccept),
        .dmaStart    (dmaStart),
        .slotBlock   (slotBlock)
    );

    refreshTimer refreshTimer_inst (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .refreshDone (refreshDone),
        .refreshReq  (refreshReq)
    );

    // Command bus and status outputs
    sdramSequencer sdramSequencer_inst (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .cpuReq      (cpuReq),
        .agnusRev    (agnusRev),
        .agnusWe     (agnusBus.aweN),
        .dmaAddr     (dmaAddr),
        .dmaStart    (dmaStart),
        .slotBlock   (slotBlock),
        .refreshReq  (refreshReq),
        .refreshDone (refreshDone),
        .dmaAccept   (dmaAccept),
        .sdram       (sdram),
        .dmaStatus   (dmaStatus),
        .cpuStatus   (cpuStatus)
    );

endmodule

// ==== tb/chipRamTb.sv ====
`include "chipRam_cfg.svh"

module chipRamTb import chipRamPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int CPU_PER_REV = 8;
    // Init, CPU, DMA, slot test and the idle refresh run
    localparam int TEST_CYCLES = 60 + 2 * CPU_PER_REV * 40 + 4 * 80 + 120
                               + 5 * (`REFRESH_PERIOD + 20);

    logic      C1;
    logic      REFRESH_RST;
    agnusBusT  agnusBus;
    cpuReqT    cpuReq;
    logic      agnusRev;
    sdramBusT  sdram;
    dmaStatusT dmaStatus;
    cpuStatusT cpuStatus;

    sdramCmdE    pinCmd;
    logic [31:0] lfsr;
    int          errors;
    int          cycle;
    int          refCount;
    int          cpuActCount;
    int          dmaActCount;
    int          tackCount;
    int          latchCount;
    logic        tackQ;
    logic        latchQ;
    logic        blockWindow;
    logic [9:0]  expDmaRow;
    logic        expDmaWrite;
    logic        expA1;
    sdramCmdE    initCmds[$];
    int          refTimes[$];

    chipRamTop chipRamTop_inst (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .agnusBus    (agnusBus),
        .cpuReq      (cpuReq),
        .agnusRev    (agnusRev),
        .sdram       (sdram),
        .dmaStatus   (dmaStatus),
        .cpuStatus   (cpuStatus)
    );

    // Command lines as one enum value
    assign pinCmd = sdramCmdE'({sdram.csN, sdram.rasN, sdram.casN, sdram.weN});

    initial begin
        C1 = 1'b0;
        forever #(CLK_PERIOD / 2) C1 = ~C1;
    end

    // Twice the expected run length
    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic logFailure(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    // One step for each bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // CPU address to SDRAM row
    function automatic logic [9:0] cpuRowOf(input logic [20:2] a);
        return {a[19], a[17:9]};
    endfunction

    // MA9 of the column only on the later revision
    function automatic logic [8:0] cpuColOf(input logic [20:2] a, input logic rev);
        return {rev & a[20], a[18], a[8:2]};
    endfunction

    // DMA chip strobes all negated
    task automatic idleBus();
        agnusBus <= '{rasN: 2'b11, casN: 2'b11, aweN: 1'b1, dbrN: 1'b1, dra: 10'd0};
    endtask

    ////////////////////
    // Command monitor
    ////////////////////

    // DUT outputs are settled at the falling edge
    always @(negedge C1) begin
        if (!REFRESH_RST) begin
            cycle++;
            // First four commands make up the power-up sequence
            if (pinCmd != NOP && initCmds.size() < 4) begin
                if (initCmds.size() == 0 && !sdram.cma.addrView.a10)
                    logFailure("init PRECHARGE without A10");
                if (pinCmd == MODEREG && (sdram.cma.modeView.casLat != 3'd2 ||
                        sdram.cma.modeView.burstType || sdram.cma.modeView.burstLen != 3'b010))
                    logFailure("mode word not CL 2, sequential, length 4");
                initCmds.push_back(pinCmd);
            end
            if (pinCmd == ACTIVATE && refCount < 2)
                logFailure("ACTIVATE before init finished");
            if (pinCmd == AUTOREFRESH) begin
                refCount++;
                refTimes.push_back(cycle);
            end
            if (pinCmd == ACTIVATE && cpuStatus.cpuCycle)
                cpuActCount++;
            if (pinCmd == ACTIVATE && dmaStatus.dmaCycle)
                dmaActCount++;
            // Rising edges of the pulses
            if (cpuStatus.cpuTack && !tackQ)
                tackCount++;
            if (dmaStatus.latchClk && !latchQ)
                latchCount++;
            tackQ  = cpuStatus.cpuTack;
            latchQ = dmaStatus.latchClk;
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    // Single-word access spacing
    aRwAfterAct: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == ACTIVATE |=> (pinCmd == READ || pinCmd == WRITE) ##1 pinCmd == PRECHARGE)
        else logFailure("READ/WRITE or PRECHARGE not 1 cycle apart");
    // Only bank 0 in use
    aBankZero: assert property (@(posedge C1) disable iff (REFRESH_RST)
        sdram.bank == 2'b00)
        else logFailure("bank bits not zero");
    aCpuRow: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == ACTIVATE && cpuStatus.cpuCycle |->
            !sdram.cma.addrView.a10 && sdram.cma.addrView.rowCol == cpuRowOf(cpuReq.addr))
        else logFailure("CPU row mismatch");
    aCpuCol: assert property (@(posedge C1) disable iff (REFRESH_RST)
        (pinCmd == READ || pinCmd == WRITE) && cpuStatus.cpuCycle |->
            sdram.cma.addrView.rowCol == {1'b0, cpuColOf(cpuReq.addr, agnusRev)} &&
            (pinCmd == WRITE) == !cpuReq.rnW)
        else logFailure("CPU column or direction mismatch");
    // Write tack together with WRITE at the pins
    aWriteTack: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == WRITE && cpuStatus.cpuCycle |->
            cpuStatus.cpuTack && cpuStatus.clkEn ##1 !cpuStatus.cpuTack)
        else logFailure("write tack not with WRITE");
    // Read tack 3 cycles after PRECHARGE
    aReadTack: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == READ && cpuStatus.cpuCycle |->
            ##4 (cpuStatus.cpuTack && !cpuStatus.clkEn) ##1 !cpuStatus.cpuTack)
        else logFailure("read tack or clkEn wrong");
    aWriteClk: assert property (@(posedge C1) disable iff (REFRESH_RST)
        cpuStatus.cpuCycle && !cpuReq.rnW |-> cpuStatus.clkEn)
        else logFailure("clkEn dropped on a write");
    aDmaAct: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == ACTIVATE && dmaStatus.dmaCycle |->
            sdram.cma.addrView.rowCol == expDmaRow && dmaStatus.dmaWriteCycle == expDmaWrite &&
            dmaStatus.dbDir == expDmaWrite && dmaStatus.dbEnN == !expA1)
        else logFailure("DMA row or status mismatch");
    aDmaLatch: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == READ && dmaStatus.dmaCycle |->
            ##4 dmaStatus.latchClk ##1 !dmaStatus.latchClk)
        else logFailure("latchClk not one pulse on DMA read");
    aRefNops: assert property (@(posedge C1) disable iff (REFRESH_RST)
        pinCmd == AUTOREFRESH |=> pinCmd == NOP [*3])
        else logFailure("fewer than 3 NOPs after AUTOREFRESH");
    aSlotBlock: assert property (@(posedge C1) disable iff (REFRESH_RST)
        blockWindow |-> !(pinCmd == ACTIVATE && cpuStatus.cpuCycle))
        else logFailure("CPU ACTIVATE inside blocked slot");

    ////////////////////
    // Stimulus
    ////////////////////

    // One-cycle transfer start, address stays on the bus
    task automatic cpuRequest(input logic [20:2] addr, input logic rnW);
        @(posedge C1);
        cpuReq <= '{tsN: 1'b0, ramSpaceN: 1'b0, rnW: rnW, addr: addr};
        @(posedge C1);
        cpuReq.tsN <= 1'b1;
    endtask

    // Random address and direction from the LFSR
    task automatic randomCpuRequest();
        logic [31:0] addrBits;
        logic [31:0] dirBits;
        addrBits = randBits(19);
        dirBits  = randBits(1);
        cpuRequest(addrBits[18:0], dirBits[0]);
    endtask

    // Address held until the cycle is over
    task automatic finishCpu(input int startTack);
        int i;
        for (i = 0; i < 60 && !(tackCount > startTack && !cpuStatus.cpuCycle); i++)
            @(posedge C1);
        if (tackCount != startTack + 1)
            logFailure("cpuTack count wrong for one access");
        if (cpuStatus.cpuCycle) begin
            $display("Timeout waiting for the CPU cycle to end");
            errors++;
        end
    endtask

    task automatic cpuAccess();
        int startTack;
        startTack = tackCount;
        randomCpuRequest();
        finishCpu(startTack);
    endtask

    task automatic dmaTransfer(input logic doWrite);
        logic [31:0] bits;
        logic [9:0]  colWord;
        logic [9:0]  rowWord;
        logic        rasSel;
        int          startActs;
        int          startLatch;
        int          i;
        bits        = randBits(10);
        colWord     = bits[9:0];
        bits        = randBits(10);
        rowWord     = bits[9:0];
        bits        = randBits(1);
        rasSel      = bits[0];
        // Earlier revision shifts DRA down, top row bit from RAS0
        expDmaRow   = agnusRev ? rowWord : {rasSel, rowWord[9:1]};
        expA1       = agnusRev ? colWord[0] : colWord[1];
        expDmaWrite = doWrite;
        startActs   = dmaActCount;
        startLatch  = latchCount;
        // Column strobe first so A1 is known at the grant
        @(posedge C1);
        agnusBus.dbrN <= 1'b0;
        agnusBus.casN <= 2'b00;
        agnusBus.dra  <= colWord;
        repeat (2) @(posedge C1);
        agnusBus.casN <= 2'b11;
        repeat (4) @(posedge C1);
        // One RAS line low carries the row
        agnusBus.rasN <= {~rasSel, rasSel};
        agnusBus.dra  <= rowWord;
        agnusBus.aweN <= !doWrite;
        for (i = 0; i < 60 && dmaActCount == startActs; i++)
            @(posedge C1);
        if (dmaActCount == startActs)
            logFailure("no ACTIVATE for the DMA cycle");
        for (i = 0; i < 40 && !(dmaActCount > startActs && !dmaStatus.dmaCycle); i++)
            @(posedge C1);
        if (dmaStatus.dmaCycle) begin
            $display("Timeout waiting for the DMA cycle to end");
            errors++;
        end
        idleBus();
        // Reads latch once, writes never
        if (latchCount != startLatch + (doWrite ? 0 : 1))
            logFailure("latchClk pulse count wrong");
        repeat (4) @(posedge C1);
    endtask

    // CAS run shorter than the gap keeps the CPU out
    task automatic slotCheck();
        int startTack;
        startTack = tackCount;
        @(posedge C1);
        agnusBus.dbrN <= 1'b0;
        repeat (4) @(posedge C1);
        blockWindow = 1'b1;
        agnusBus.casN <= 2'b00;
        randomCpuRequest();
        repeat (`CAS_GAP_CNT - 5) @(posedge C1);
        idleBus();
        blockWindow = 1'b0;
        // Pending request served once the bus is free
        finishCpu(startTack);
    endtask

    // Four refreshes with no other traffic
    task automatic refreshIdle();
        int s;
        int i;
        s = refCount;
        for (i = 0; i < 5 * (`REFRESH_PERIOD + 20) && refCount < s + 4; i++)
            @(posedge C1);
        if (refCount < s + 4) begin
            logFailure("AUTOREFRESH did not recur");
        end else begin
            for (i = s + 1; i <= s + 3; i++) begin
                if (refTimes[i] - refTimes[i-1] < `REFRESH_PERIOD ||
                        refTimes[i] - refTimes[i-1] > `REFRESH_PERIOD + 20)
                    logFailure("refresh interval out of range");
            end
        end
    endtask

    initial begin
        sdramCmdE initExp[4];
        initExp     = '{PRECHARGE, MODEREG, AUTOREFRESH, AUTOREFRESH};
        errors      = 0;
        cycle       = 0;
        refCount    = 0;
        cpuActCount = 0;
        dmaActCount = 0;
        tackCount   = 0;
        latchCount  = 0;
        tackQ       = 1'b0;
        latchQ      = 1'b0;
        blockWindow = 1'b0;
        expDmaRow   = '0;
        expDmaWrite = 1'b0;
        expA1       = 1'b0;
        lfsr        = 32'he993_88d7;
        REFRESH_RST = 1'b1;
        agnusRev    = 1'b0;
        cpuReq      = '{tsN: 1'b1, ramSpaceN: 1'b1, rnW: 1'b1, addr: '0};
        agnusBus    = '{rasN: 2'b11, casN: 2'b11, aweN: 1'b1, dbrN: 1'b1, dra: 10'd0};
        repeat (8) @(posedge C1);
        REFRESH_RST <= 1'b0;
        // Power-up sequence ends at step 15
        repeat (30) @(posedge C1);
        if (initCmds.size() < 4)
            logFailure("init sequence incomplete");
        for (int i = 0; i < initCmds.size(); i++) begin
            if (initCmds[i] != initExp[i])
                logFailure("init command order wrong");
        end
        // CPU then DMA accesses under both revisions
        for (int rev = 0; rev < 2; rev++) begin
            @(posedge C1);
            agnusRev <= rev[0];
            @(posedge C1);
            repeat (CPU_PER_REV) cpuAccess();
            dmaTransfer(1'b0);
            dmaTransfer(1'b1);
        end
        slotCheck();
        refreshIdle();
        $display("Errors %0d, CPU accesses %0d, DMA cycles %0d, refreshes %0d",
                 errors, cpuActCount, dmaActCount, refCount);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/chipRamPkg.sv
src/dmaAddrLatch.sv
src/agnusSync.sv
src/refreshTimer.sv
src/sdramSequencer.sv
src/chipRamTop.sv
tb/chipRamTb.sv

// ==== Bender.yml ====
package:
  name: chip_ram

sources:
  - include_dirs:
      - src
    files:
      - src/chipRamPkg.sv
      - src/dmaAddrLatch.sv
      - src/agnusSync.sv
      - src/refreshTimer.sv
      - src/sdramSequencer.sv
      - src/chipRamTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/chipRamTb.sv
